// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mips_id_tb
FLIST     ?= mips_id.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^TB PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/branch_resolve.sv ====
`default_nettype none
`timescale 1ns/1ns

module branch_resolve (
    input  wire mips_id_pkg::dec_ctrl_t  ctrl_i,
    input  wire mips_id_pkg::inst_u      inst_i,
    input  wire mips_id_pkg::word_t      pc_i,
    input  wire mips_id_pkg::word_t      reg1_i,
    input  wire mips_id_pkg::word_t      reg2_i,
    output mips_id_pkg::branch_t         branch_o,
    output mips_id_pkg::word_t           link_addr_o
);
    import mips_id_pkg::*;

    word_t pc_plus_4;
    word_t pc_plus_8;
    word_t br_target;
    word_t jmp_target;
    logic  sign1;
    logic  taken;

    assign pc_plus_4  = pc_i + word_t'(4);
    assign pc_plus_8  = pc_i + word_t'(8);
    assign br_target  = pc_plus_4 + {{(word_w-18){inst_i.i_fmt.imm16[15]}},
                                     inst_i.i_fmt.imm16, 2'b00};
    // Stays inside the current 256 MB region
    assign jmp_target = {pc_plus_4[word_w-1:word_w-4], inst_i.j_fmt.index26, 2'b00};
    assign sign1      = reg1_i[word_w-1];

    always_comb begin
        case (ctrl_i.aluop)
            aluop_beq:  taken = (reg1_i == reg2_i);
            aluop_bne:  taken = (reg1_i != reg2_i);
            aluop_bgtz: taken = !sign1 && (reg1_i != '0);
            aluop_blez: taken = sign1 || (reg1_i == '0);
            aluop_bgez: taken = !sign1;
            aluop_bltz: taken = sign1;
            default:    taken = 1'b0;
        endcase
    end

    always_comb begin
        branch_o = '0;
        case (ctrl_i.aluop)
            aluop_j, aluop_jal: begin
                branch_o.flag   = 1'b1;
                branch_o.target = jmp_target;
            end
            aluop_jr, aluop_jalr: begin
                branch_o.flag   = 1'b1;
                branch_o.target = reg1_i;
            end
            default: begin
                if (taken) begin
                    branch_o.flag   = 1'b1;
                    branch_o.target = br_target;
                end
            end
        endcase
    end

    // Return past the delay slot
    assign link_addr_o = (ctrl_i.aluop == aluop_jal || ctrl_i.aluop == aluop_jalr)
                       ? pc_plus_8 : '0;

endmodule

`default_nettype wire

// ==== design/id_ex_reg.sv ====
`default_nettype none
`timescale 1ns/1ns

module id_ex_reg (
    input  wire                          clk_i,
    input  wire                          arst_n_i,
    input  wire mips_id_pkg::dec_ctrl_t  ctrl_i,
    input  wire mips_id_pkg::word_t      reg1_i,
    input  wire mips_id_pkg::word_t      reg2_i,
    input  wire mips_id_pkg::word_t      link_addr_i,
    output mips_id_pkg::ex_bundle_t      ex_o
);
    import mips_id_pkg::*;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // NOP bundle
            ex_o.aluop     <= aluop_nop;
            ex_o.alusel    <= alusel_nop;
            ex_o.reg1      <= '0;
            ex_o.reg2      <= '0;
            ex_o.wd        <= '0;
            ex_o.wreg      <= 1'b0;
            ex_o.link_addr <= '0;
        end else begin
            ex_o.aluop     <= ctrl_i.aluop;
            ex_o.alusel    <= ctrl_i.alusel;
            ex_o.reg1      <= reg1_i;
            ex_o.reg2      <= reg2_i;
            ex_o.wd        <= ctrl_i.wd;
            ex_o.wreg      <= ctrl_i.wreg;
            ex_o.link_addr <= link_addr_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/inst_decoder.sv ====
`default_nettype none
`timescale 1ns/1ns

module inst_decoder (
    input  wire mips_id_pkg::inst_u   inst_i,
    output mips_id_pkg::dec_ctrl_t    ctrl_o,
    output mips_id_pkg::reg_addr_t    reg1_addr_o,
    output mips_id_pkg::reg_addr_t    reg2_addr_o
);
    import mips_id_pkg::*;

    // Variable and constant shifts share the low funct bits
    function automatic aluop_e shift_op(input logic [5:0] funct);
        case (funct[1:0])
            2'b00:   return aluop_sll;
            2'b10:   return aluop_srl;
            default: return aluop_sra;
        endcase
    endfunction

    assign reg1_addr_o = inst_i.r_fmt.rs;
    assign reg2_addr_o = inst_i.r_fmt.rt;

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.aluop  = aluop_nop;
        ctrl_o.alusel = alusel_nop;
        ctrl_o.wd     = inst_i.r_fmt.rd;
        case (inst_i.r_fmt.op)
            op_special: begin
                case (inst_i.r_fmt.funct)
                    fn_and, fn_or, fn_xor, fn_nor, fn_sllv, fn_srlv, fn_srav: begin
                        if (inst_i.r_fmt.sa == '0) begin
                            ctrl_o.wreg      = 1'b1;
                            ctrl_o.reg1_read = 1'b1;
                            ctrl_o.reg2_read = 1'b1;
                            // Logic functions all have funct[5] set
                            ctrl_o.alusel = inst_i.r_fmt.funct[5] ? alusel_logic : alusel_shift;
                            case (inst_i.r_fmt.funct)
                                fn_and:  ctrl_o.aluop = aluop_and;
                                fn_or:   ctrl_o.aluop = aluop_or;
                                fn_xor:  ctrl_o.aluop = aluop_xor;
                                fn_nor:  ctrl_o.aluop = aluop_nor;
                                default: ctrl_o.aluop = shift_op(inst_i.r_fmt.funct);
                            endcase
                        end
                    end
                    fn_sll, fn_srl, fn_sra: begin
                        if (inst_i.r_fmt.rs == '0) begin
                            ctrl_o.wreg      = 1'b1;
                            ctrl_o.aluop     = shift_op(inst_i.r_fmt.funct);
                            ctrl_o.alusel    = alusel_shift;
                            ctrl_o.reg2_read = 1'b1;
                            ctrl_o.imm       = word_t'(inst_i.r_fmt.sa);
                        end
                    end
                    fn_jr, fn_jalr: begin
                        if (inst_i.r_fmt.sa == '0) begin
                            ctrl_o.wreg      = (inst_i.r_fmt.funct == fn_jalr);
                            ctrl_o.aluop     = (inst_i.r_fmt.funct == fn_jalr) ? aluop_jalr
                                                                               : aluop_jr;
                            ctrl_o.alusel    = alusel_jump_branch;
                            ctrl_o.reg1_read = 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
            op_andi, op_ori, op_xori, op_lui: begin
                ctrl_o.wreg      = 1'b1;
                ctrl_o.alusel    = alusel_logic;
                ctrl_o.reg1_read = 1'b1;
                ctrl_o.wd        = inst_i.i_fmt.rt;
                ctrl_o.imm       = {16'h0000, inst_i.i_fmt.imm16};
                case (inst_i.i_fmt.op)
                    op_andi: ctrl_o.aluop = aluop_and;
                    op_xori: ctrl_o.aluop = aluop_xor;
                    default: ctrl_o.aluop = aluop_or;
                endcase
                // LUI is an OR with the immediate in the upper half
                if (inst_i.i_fmt.op == op_lui) begin
                    ctrl_o.imm = {inst_i.i_fmt.imm16, 16'h0000};
                end
            end
            op_j: begin
                ctrl_o.aluop  = aluop_j;
                ctrl_o.alusel = alusel_jump_branch;
            end
            op_jal: begin
                ctrl_o.wreg   = 1'b1;
                ctrl_o.aluop  = aluop_jal;
                ctrl_o.alusel = alusel_jump_branch;
                ctrl_o.wd     = link_reg;
            end
            op_beq, op_bne: begin
                ctrl_o.aluop     = (inst_i.i_fmt.op == op_beq) ? aluop_beq : aluop_bne;
                ctrl_o.alusel    = alusel_jump_branch;
                ctrl_o.reg1_read = 1'b1;
                ctrl_o.reg2_read = 1'b1;
            end
            op_blez, op_bgtz: begin
                ctrl_o.aluop     = (inst_i.i_fmt.op == op_blez) ? aluop_blez : aluop_bgtz;
                ctrl_o.alusel    = alusel_jump_branch;
                ctrl_o.reg1_read = 1'b1;
            end
            op_regimm: begin
                if (inst_i.i_fmt.rt == rt_bltz || inst_i.i_fmt.rt == rt_bgez) begin
                    ctrl_o.aluop     = (inst_i.i_fmt.rt == rt_bltz) ? aluop_bltz : aluop_bgez;
                    ctrl_o.alusel    = alusel_jump_branch;
                    ctrl_o.reg1_read = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/mips_id.sv ====
`default_nettype none
`timescale 1ns/1ns

module mips_id (
    input  wire                          clk_i,
    input  wire                          arst_n_i,
    input  wire mips_id_pkg::word_t      pc_i,
    input  wire mips_id_pkg::inst_u      inst_i,
    input  wire mips_id_pkg::word_t      reg1_data_i,
    input  wire mips_id_pkg::word_t      reg2_data_i,
    input  wire mips_id_pkg::fwd_t       ex_fwd_i,
    input  wire mips_id_pkg::fwd_t       mem_fwd_i,
    output logic                         reg1_read_o,
    output logic                         reg2_read_o,
    output mips_id_pkg::reg_addr_t       reg1_addr_o,
    output mips_id_pkg::reg_addr_t       reg2_addr_o,
    output mips_id_pkg::branch_t         branch_o,
    output mips_id_pkg::ex_bundle_t      ex_o
);
    import mips_id_pkg::*;

    dec_ctrl_t ctrl;
    word_t     reg1;
    word_t     reg2;
    word_t     link_addr;

    inst_decoder u_decoder (
        .inst_i      (inst_i),
        .ctrl_o      (ctrl),
        .reg1_addr_o (reg1_addr_o),
        .reg2_addr_o (reg2_addr_o)
    );

    // Register file requests
    assign reg1_read_o = ctrl.reg1_read;
    assign reg2_read_o = ctrl.reg2_read;

    operand_bypass u_bypass (
        .ctrl_i      (ctrl),
        .reg1_addr_i (reg1_addr_o),
        .reg2_addr_i (reg2_addr_o),
        .reg1_data_i (reg1_data_i),
        .reg2_data_i (reg2_data_i),
        .ex_fwd_i    (ex_fwd_i),
        .mem_fwd_i   (mem_fwd_i),
        .reg1_o      (reg1),
        .reg2_o      (reg2)
    );

    branch_resolve u_branch (
        .ctrl_i      (ctrl),
        .inst_i      (inst_i),
        .pc_i        (pc_i),
        .reg1_i      (reg1),
        .reg2_i      (reg2),
        .branch_o    (branch_o),
        .link_addr_o (link_addr)
    );

    id_ex_reg u_id_ex (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .ctrl_i      (ctrl),
        .reg1_i      (reg1),
        .reg2_i      (reg2),
        .link_addr_i (link_addr),
        .ex_o        (ex_o)
    );

endmodule

`default_nettype wire

// ==== design/mips_id_pkg.sv ====
`default_nettype none

package mips_id_pkg;

    localparam int unsigned word_w     = 32;
    localparam int unsigned reg_addr_w = 5;
    localparam int unsigned aluop_w    = 8;
    localparam int unsigned alusel_w   = 3;

    typedef logic [word_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // Primary opcodes
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_regimm  = 6'b000001;
    localparam logic [5:0] op_j       = 6'b000010;
    localparam logic [5:0] op_jal     = 6'b000011;
    localparam logic [5:0] op_beq     = 6'b000100;
    localparam logic [5:0] op_bne     = 6'b000101;
    localparam logic [5:0] op_blez    = 6'b000110;
    localparam logic [5:0] op_bgtz    = 6'b000111;
    localparam logic [5:0] op_andi    = 6'b001100;
    localparam logic [5:0] op_ori     = 6'b001101;
    localparam logic [5:0] op_xori    = 6'b001110;
    localparam logic [5:0] op_lui     = 6'b001111;

    // SPECIAL function field
    localparam logic [5:0] fn_and  = 6'b100100;
    localparam logic [5:0] fn_or   = 6'b100101;
    localparam logic [5:0] fn_xor  = 6'b100110;
    localparam logic [5:0] fn_nor  = 6'b100111;
    localparam logic [5:0] fn_sll  = 6'b000000;
    localparam logic [5:0] fn_srl  = 6'b000010;
    localparam logic [5:0] fn_sra  = 6'b000011;
    localparam logic [5:0] fn_sllv = 6'b000100;
    localparam logic [5:0] fn_srlv = 6'b000110;
    localparam logic [5:0] fn_srav = 6'b000111;
    localparam logic [5:0] fn_jr   = 6'b001000;
    localparam logic [5:0] fn_jalr = 6'b001001;

    // REGIMM rt field
    localparam reg_addr_t rt_bltz = 5'b00000;
    localparam reg_addr_t rt_bgez = 5'b00001;

    localparam reg_addr_t link_reg = 5'd31;

    typedef enum logic [aluop_w-1:0] {
        aluop_nop  = 8'b0000_0000,
        aluop_or   = 8'b0010_0101,
        aluop_and  = 8'b0010_0100,
        aluop_xor  = 8'b0010_0110,
        aluop_nor  = 8'b0010_0111,
        aluop_sll  = 8'b0111_1100,
        aluop_srl  = 8'b0000_0010,
        aluop_sra  = 8'b0000_0011,
        aluop_j    = 8'b0100_1111,
        aluop_jal  = 8'b0101_0000,
        aluop_jr   = 8'b0000_1000,
        aluop_jalr = 8'b0000_1001,
        aluop_beq  = 8'b0101_0001,
        aluop_bne  = 8'b0101_0010,
        aluop_bgtz = 8'b0101_0100,
        aluop_blez = 8'b0101_0011,
        aluop_bgez = 8'b0100_0001,
        aluop_bltz = 8'b0100_0000
    } aluop_e;

    typedef enum logic [alusel_w-1:0] {
        alusel_nop         = 3'b000,
        alusel_logic       = 3'b001,
        alusel_shift       = 3'b010,
        alusel_jump_branch = 3'b110
    } alusel_e;

    typedef struct packed {
        logic [5:0] op;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm16;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] index26;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef struct packed {
        aluop_e    aluop;
        alusel_e   alusel;
        logic      reg1_read;
        logic      reg2_read;
        reg_addr_t wd;
        logic      wreg;
        word_t     imm;
    } dec_ctrl_t;

    typedef struct packed {
        logic      wreg;
        reg_addr_t wd;
        word_t     wdata;
    } fwd_t;

    typedef struct packed {
        logic  flag;
        word_t target;
    } branch_t;

    typedef struct packed {
        aluop_e    aluop;
        alusel_e   alusel;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;
        logic      wreg;
        word_t     link_addr;
    } ex_bundle_t;

endpackage

`default_nettype wire

// ==== design/operand_bypass.sv ====
`default_nettype none
`timescale 1ns/1ns

module operand_bypass (
    input  wire mips_id_pkg::dec_ctrl_t  ctrl_i,
    input  wire mips_id_pkg::reg_addr_t  reg1_addr_i,
    input  wire mips_id_pkg::reg_addr_t  reg2_addr_i,
    input  wire mips_id_pkg::word_t      reg1_data_i,
    input  wire mips_id_pkg::word_t      reg2_data_i,
    input  wire mips_id_pkg::fwd_t       ex_fwd_i,
    input  wire mips_id_pkg::fwd_t       mem_fwd_i,
    output mips_id_pkg::word_t           reg1_o,
    output mips_id_pkg::word_t           reg2_o
);
    import mips_id_pkg::*;

    // EX result is younger, so it beats MEM
    function automatic word_t pick(input logic rd_en, input reg_addr_t addr,
                                   input word_t rf_data, input fwd_t ex_f,
                                   input fwd_t mem_f, input word_t imm);
        word_t res;
        if (rd_en && ex_f.wreg && ex_f.wd == addr) begin
            res = ex_f.wdata;
        end else if (rd_en && mem_f.wreg && mem_f.wd == addr) begin
            res = mem_f.wdata;
        end else if (rd_en) begin
            res = rf_data;
        end else begin
            res = imm;
        end
        return res;
    endfunction

    assign reg1_o = pick(ctrl_i.reg1_read, reg1_addr_i, reg1_data_i, ex_fwd_i, mem_fwd_i,
                         ctrl_i.imm);
    assign reg2_o = pick(ctrl_i.reg2_read, reg2_addr_i, reg2_data_i, ex_fwd_i, mem_fwd_i,
                         ctrl_i.imm);

endmodule

`default_nettype wire

// ==== dv/mips_id_asserts.sv ====
`default_nettype none
`timescale 1ns/1ns

module mips_id_asserts (
    input wire                         clk_i,
    input wire                         arst_n_i,
    input wire mips_id_pkg::dec_ctrl_t ctrl_i,
    input wire mips_id_pkg::branch_t   branch_o,
    input wire mips_id_pkg::ex_bundle_t ex_o
);
    import mips_id_pkg::*;

    // Only jump and branch decodes may redirect the PC
    a_flag_is_jb: assert property (@(posedge clk_i)
        branch_o.flag |-> ctrl_i.alusel == alusel_jump_branch)
        else $error("branch flag raised outside a jump or branch");

    a_reset_no_write: assert property (@(posedge clk_i)
        !arst_n_i |-> !ex_o.wreg)
        else $error("ex_o.wreg high during reset");

    a_jal_link: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ex_o.aluop == aluop_jal |-> ex_o.wd == link_reg)
        else $error("JAL bundle does not write the link register");

endmodule

bind mips_id mips_id_asserts u_asserts (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .ctrl_i   (ctrl),
    .branch_o (branch_o),
    .ex_o     (ex_o)
);

`default_nettype wire

// ==== dv/mips_id_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

module mips_id_tb;
    import mips_id_pkg::*;

    localparam int n_inst = 40;
    // Five groups of n_inst plus reset, with plenty of margin
    localparam int max_cycles = 1000;

    logic clk_i = 1'b0;
    logic arst_n_i;
    word_t pc_i, reg1_data_i, reg2_data_i;
    inst_u inst_i;
    fwd_t ex_fwd_i, mem_fwd_i;
    logic reg1_read_o, reg2_read_o;
    reg_addr_t reg1_addr_o, reg2_addr_o;
    branch_t branch_o;
    ex_bundle_t ex_o;

    word_t regs [32];
    logic [31:0] rng = 32'd53;
    ex_bundle_t exp_ex;
    branch_t exp_br;
    // Read enable and address for rs, then for rt
    logic [11:0] exp_rq;
    logic check_en = 1'b0;
    string cur_test = "reset";
    string group_name [5] = '{"logic", "shift", "forward", "branch", "jump"};
    int checks = 0, errors = 0, test_errors = 0, tests = 0, cycles = 0;

    mips_id dut0 (.*);

    always #50 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic word_t rnd();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic word_t r_inst(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input logic [4:0] sa,
                                     input logic [5:0] fn);
        return {op_special, rs, rt, rd, sa, fn};
    endfunction

    // Priority EX, MEM, register file, then immediate
    function automatic word_t operand(input logic rd_en, input reg_addr_t a, input fwd_t exf,
                                      input fwd_t memf, input word_t imm);
        if (!rd_en) return imm;
        if (exf.wreg && exf.wd == a) return exf.wdata;
        if (memf.wreg && memf.wd == a) return memf.wdata;
        return regs[a];
    endfunction

    function automatic void ref_model(input word_t ins, input word_t pc, input fwd_t exf,
                                      input fwd_t memf, output ex_bundle_t e,
                                      output branch_t b, output logic [11:0] rq);
        logic [5:0] op, fn;
        reg_addr_t rs, rt;
        logic [4:0] sa;
        logic [15:0] imm16;
        logic r1rd, r2rd, take;
        word_t imm, a, c, pc4;
        op = ins[31:26];
        rs = ins[25:21];
        rt = ins[20:16];
        sa = ins[10:6];
        fn = ins[5:0];
        imm16 = ins[15:0];
        e = '0;
        b = '0;
        r1rd = 1'b0;
        r2rd = 1'b0;
        imm = '0;
        e.wd = ins[15:11];
        pc4 = pc + 32'd4;
        case (op)
            op_special: begin
                if (fn inside {fn_and, fn_or, fn_xor, fn_nor} && sa == 0) begin
                    {e.wreg, r1rd, r2rd} = 3'b111;
                    e.alusel = alusel_logic;
                    e.aluop = fn == fn_and ? aluop_and : fn == fn_or ? aluop_or
                            : fn == fn_xor ? aluop_xor : aluop_nor;
                end else if (fn inside {fn_sllv, fn_srlv, fn_srav} && sa == 0) begin
                    {e.wreg, r1rd, r2rd} = 3'b111;
                    e.alusel = alusel_shift;
                    e.aluop = fn == fn_sllv ? aluop_sll : fn == fn_srlv ? aluop_srl : aluop_sra;
                end else if (fn inside {fn_sll, fn_srl, fn_sra} && rs == 0) begin
                    {e.wreg, r2rd} = 2'b11;
                    e.alusel = alusel_shift;
                    e.aluop = fn == fn_sll ? aluop_sll : fn == fn_srl ? aluop_srl : aluop_sra;
                    imm = {27'd0, sa};
                end else if (fn inside {fn_jr, fn_jalr} && sa == 0) begin
                    r1rd = 1'b1;
                    e.wreg = (fn == fn_jalr);
                    e.alusel = alusel_jump_branch;
                    e.aluop = fn == fn_jalr ? aluop_jalr : aluop_jr;
                end
            end
            op_andi, op_ori, op_xori, op_lui: begin
                {e.wreg, r1rd} = 2'b11;
                e.wd = rt;
                e.alusel = alusel_logic;
                e.aluop = op == op_andi ? aluop_and : op == op_xori ? aluop_xor : aluop_or;
                imm = op == op_lui ? {imm16, 16'h0000} : {16'h0000, imm16};
            end
            op_j, op_jal: begin
                e.alusel = alusel_jump_branch;
                e.aluop = op == op_j ? aluop_j : aluop_jal;
                if (op == op_jal) begin
                    e.wreg = 1'b1;
                    e.wd = link_reg;
                end
            end
            op_beq, op_bne, op_blez, op_bgtz: begin
                {r1rd, r2rd} = {1'b1, op == op_beq || op == op_bne};
                e.alusel = alusel_jump_branch;
                e.aluop = op == op_beq ? aluop_beq : op == op_bne ? aluop_bne
                        : op == op_blez ? aluop_blez : aluop_bgtz;
            end
            op_regimm: begin
                if (rt == rt_bltz || rt == rt_bgez) begin
                    r1rd = 1'b1;
                    e.alusel = alusel_jump_branch;
                    e.aluop = rt == rt_bltz ? aluop_bltz : aluop_bgez;
                end
            end
            default: begin
            end
        endcase
        a = operand(r1rd, rs, exf, memf, imm);
        c = operand(r2rd, rt, exf, memf, imm);
        e.reg1 = a;
        e.reg2 = c;
        case (e.aluop)
            aluop_beq:  take = (a == c);
            aluop_bne:  take = (a != c);
            aluop_bgtz: take = !a[31] && a != 0;
            aluop_blez: take = a[31] || a == 0;
            aluop_bgez: take = !a[31];
            aluop_bltz: take = a[31];
            default:    take = 1'b0;
        endcase
        if (e.aluop == aluop_j || e.aluop == aluop_jal) begin
            b = {1'b1, pc4[31:28], ins[25:0], 2'b00};
        end else if (e.aluop == aluop_jr || e.aluop == aluop_jalr) begin
            b = {1'b1, a};
        end else if (take) begin
            b = {1'b1, pc4 + {{14{imm16[15]}}, imm16, 2'b00}};
        end
        if (e.aluop == aluop_jal || e.aluop == aluop_jalr) e.link_addr = pc + 32'd8;
        rq = {r1rd, rs, r2rd, rt};
    endfunction

    task automatic compare(input string what, input logic [127:0] exp, input logic [127:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            test_errors++;
            $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic issue(input word_t ins, input word_t pc, input fwd_t exf, input fwd_t memf);
        @(negedge clk_i);
        inst_i = inst_u'(ins);
        pc_i = pc;
        reg1_data_i = regs[ins[25:21]];
        reg2_data_i = regs[ins[20:16]];
        ex_fwd_i = exf;
        mem_fwd_i = memf;
        ref_model(ins, pc, exf, memf, exp_ex, exp_br, exp_rq);
        check_en = 1'b1;
    endtask

    task automatic end_test();
        @(posedge clk_i);
        #2;
        tests++;
        $display("test %s done with %0d errors", cur_test, test_errors);
        test_errors = 0;
    endtask

    // Branch and read requests before the edge, latched bundle just after it
    always begin : compare_proc
        ex_bundle_t pend;
        @(posedge clk_i);
        if (check_en) begin
            compare("branch_o", 128'(exp_br), 128'(branch_o));
            compare("read_req", 128'(exp_rq),
                    128'({reg1_read_o, reg1_addr_o, reg2_read_o, reg2_addr_o}));
            pend = exp_ex;
            #1;
            compare("ex_o", 128'(pend), 128'(ex_o));
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        word_t pc, ins;
        reg_addr_t rs, rt, rd;
        fwd_t exf, memf;
        logic [5:0] fn;
        arst_n_i = 1'b0;
        pc_i = '0;
        inst_i = '0;
        reg1_data_i = '0;
        reg2_data_i = '0;
        ex_fwd_i = '0;
        mem_fwd_i = '0;
        for (int i = 0; i < 32; i++) regs[i] = rnd();
        repeat (3) begin
            @(posedge clk_i);
            #1;
            compare("ex_o", '0, 128'(ex_o));
        end
        @(negedge clk_i);
        arst_n_i = 1'b1;
        #1;
        compare("ex_o", '0, 128'(ex_o));
        end_test();

        for (int g = 0; g < 5; g++) begin
            cur_test = group_name[g];
            for (int k = 0; k < n_inst; k++) begin
                rs = 5'(rnd());
                rt = 5'(rnd());
                rd = 5'(rnd());
                pc = rnd() & 32'hffff_fffc;
                exf = '0;
                memf = '0;
                case (g)
                    0: begin
                        fn = k % 2 ? fn_or : fn_nor;
                        if (k % 4 == 2) fn = fn_and;
                        if (k % 4 == 3) fn = fn_xor;
                        ins = k % 3 == 0 ? r_inst(rs, rt, rd, 0, fn)
                            : {6'b0011_00 | 6'(k % 4), rs, rt, 16'(rnd())};
                    end
                    1: begin
                        fn = k % 6 == 0 ? fn_sllv : k % 6 == 1 ? fn_srlv : k % 6 == 2 ? fn_srav
                           : k % 6 == 3 ? fn_sll : k % 6 == 4 ? fn_srl : fn_sra;
                        ins = k % 6 < 3 ? r_inst(rs, rt, rd, 0, fn)
                                        : r_inst(0, rt, rd, 5'(rnd()), fn);
                    end
                    2: begin
                        ins = r_inst(rs, rt, rd, 0, fn_xor);
                        exf.wreg   = 1'(rnd());
                        exf.wd     = 1'(rnd()) ? rs : rt;
                        exf.wdata  = rnd();
                        memf.wreg  = 1'(rnd());
                        memf.wd    = 1'(rnd()) ? rt : rs;
                        memf.wdata = rnd();
                    end
                    3: begin
                        // Zero, positive and negative rs on successive passes
                        case ((k / 6) % 3)
                            0: regs[rs] = '0;
                            1: regs[rs] = (rnd() & 32'h7fff_ffff) | 32'd1;
                            default: regs[rs] = rnd() | 32'h8000_0000;
                        endcase
                        if ((k / 6) % 2 == 0) regs[rt] = regs[rs];
                        case (k % 6)
                            0: ins = {op_beq, rs, rt, 16'(rnd())};
                            1: ins = {op_bne, rs, rt, 16'(rnd())};
                            2: ins = {op_bgtz, rs, 5'd0, 16'(rnd())};
                            3: ins = {op_blez, rs, 5'd0, 16'(rnd())};
                            4: ins = {op_regimm, rs, rt_bgez, 16'(rnd())};
                            default: ins = {op_regimm, rs, rt_bltz, 16'(rnd())};
                        endcase
                    end
                    default: begin
                        case (k % 4)
                            0: ins = {op_j, 26'(rnd())};
                            1: ins = {op_jal, 26'(rnd())};
                            2: ins = r_inst(rs, 0, 0, 0, fn_jr);
                            default: ins = r_inst(rs, 0, rd, 0, fn_jalr);
                        endcase
                    end
                endcase
                issue(ins, pc, exf, memf);
            end
            end_test();
        end

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mips_id.f ====
design/mips_id_pkg.sv
design/inst_decoder.sv
design/operand_bypass.sv
design/branch_resolve.sv
design/id_ex_reg.sv
design/mips_id.sv
dv/mips_id_asserts.sv
dv/mips_id_tb.sv
